//--- dds_modulation_lab.f
+incdir+.
dds_pkg.sv
mode_if.sv
carrier_if.sv
key_mode_control.sv
lfsr_source.sv
dds_phase_gen.sv
modulation_select.sv
dds_modulation_lab.sv
dds_modulation_lab_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f dds_modulation_lab.f --top-module dds_modulation_lab_tb -o sim_dds_modulation_lab

sim_output=$(./obj_dir/sim_dds_modulation_lab)
echo "$sim_output"

if grep -qF "All tests passed!" <<< "$sim_output"; then
	exit 0
fi
exit 1

//--- dds_modulation_lab_tb.sv
`timescale 1ns/1ps
`default_nettype none

module dds_modulation_lab_tb;

	`include "sine_quarter.svh"

	localparam int NUM_TESTS    = 5;
	localparam int TEST_CYCLES  = 600;
	localparam int RESET_CYCLES = 3;
	localparam int MAX_CYCLES   = RESET_CYCLES + NUM_TESTS * TEST_CYCLES + 197;  // 3200

	logic                                CLK_25MHZ;
	logic                                reset_from_key;
	logic                                key_event_ready;
	logic [7:0]                          key_event_type;
	logic [dds_pkg::PHASE_W-1:0]         dds_increment;
	logic [dds_pkg::NUM_KEYS-1:0]        held_keys;
	logic [dds_pkg::LFSR_W-1:0]          lfsr_value;
	logic signed [dds_pkg::SAMPLE_W-1:0] selected_signal;
	logic signed [dds_pkg::SAMPLE_W-1:0] selected_modulation;

	// reference model state
	logic [dds_pkg::NUM_KEYS-1:0]        m_held;
	logic [dds_pkg::SEL_W-1:0]           m_sig_sel;
	logic [dds_pkg::SEL_W-1:0]           m_mod_sel;
	int                                  m_tick;
	logic [dds_pkg::LFSR_W-1:0]          m_lfsr;
	logic [dds_pkg::PHASE_W-1:0]         m_phase;
	logic signed [dds_pkg::SAMPLE_W-1:0] m_sine;
	logic signed [dds_pkg::SAMPLE_W-1:0] m_cos;
	logic signed [dds_pkg::SAMPLE_W-1:0] m_saw;
	logic signed [dds_pkg::SAMPLE_W-1:0] m_square;
	logic signed [dds_pkg::SAMPLE_W-1:0] m_sel_sig;
	logic signed [dds_pkg::SAMPLE_W-1:0] m_sel_mod;

	logic [15:0] rng_state;
	logic [31:0] rnd;
	int          cycle_count = 0;
	int          test_id;
	int          test_errors;
	int          failed_tests;
	int          total_errors;
	string       test_name;
	string       test_names [0:NUM_TESTS-1] = '{
		"held_keys", "lfsr_value", "selected_signal", "modulation_ask_bpsk_lfsr", "fsk"
	};

	dds_modulation_lab dut (
		.CLK_25MHZ           (CLK_25MHZ),
		.reset_from_key      (reset_from_key),
		.key_event_ready     (key_event_ready),
		.key_event_type      (key_event_type),
		.dds_increment       (dds_increment),
		.held_keys           (held_keys),
		.lfsr_value          (lfsr_value),
		.selected_signal     (selected_signal),
		.selected_modulation (selected_modulation)
	);

	always #20 CLK_25MHZ = ~CLK_25MHZ;  // 25 MHz

	////////////////////////////////////////////////////////////
	// random source from a 16-bit galois lfsr
	////////////////////////////////////////////////////////////
	function automatic logic [15:0] galois_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic draw_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			v = {v[30:0], rng_state[0]};  // one step per bit
			rng_state = galois_next(rng_state);
		end
	endtask

	////////////////////////////////////////////////////////////
	// waveform rules
	////////////////////////////////////////////////////////////
	function automatic logic signed [dds_pkg::SAMPLE_W-1:0] sine_of(input logic [31:0] phase);
		logic signed [dds_pkg::SAMPLE_W-1:0] value;
		case (phase[31:30])
			2'd0: value = SINE_QUARTER[phase[29:26]];
			2'd1: value = SINE_QUARTER[4'd15 - phase[29:26]];
			2'd2: value = -SINE_QUARTER[phase[29:26]];
			default: value = -SINE_QUARTER[4'd15 - phase[29:26]];
		endcase
		return value;
	endfunction

	function automatic logic signed [dds_pkg::SAMPLE_W-1:0] saw_of(input logic [31:0] phase);
		int index;
		index = int'(phase[31:26]);
		return 12'(index * 64 - 2048);
	endfunction

	function automatic logic signed [dds_pkg::SAMPLE_W-1:0] square_of(input logic [31:0] phase);
		return (phase[31:26] < 6'd32) ? dds_pkg::SAMPLE_MAX : -dds_pkg::SAMPLE_MAX;
	endfunction

	// one clock edge of the whole design from pre-edge values
	task automatic model_clock();
		logic        data_bit;
		logic        tick;
		logic [31:0] inc;
		data_bit = m_lfsr[0];
		tick = (m_tick == dds_pkg::LFSR_TICK_CYCLES - 1);
		inc = (m_mod_sel == dds_pkg::MOD_FSK && data_bit) ? dds_increment
			: dds_pkg::BASE_PHASE_INC;
		if (reset_from_key)
		begin
			m_held    = '0;
			m_sig_sel = dds_pkg::SIG_SINE;
			m_mod_sel = dds_pkg::MOD_ASK;
			m_tick    = 0;
			m_lfsr    = 5'b00001;
			m_phase   = '0;
			m_sine    = '0;
			m_cos     = '0;
			m_saw     = '0;
			m_square  = '0;
			m_sel_sig = '0;
			m_sel_mod = '0;
		end
		else
		begin
			case (m_sig_sel)  // output stage first so it sees the old carriers
				dds_pkg::SIG_SINE: m_sel_sig = m_sine;
				dds_pkg::SIG_COS:  m_sel_sig = m_cos;
				dds_pkg::SIG_SAW:  m_sel_sig = m_saw;
				default:           m_sel_sig = m_square;
			endcase
			case (m_mod_sel)
				dds_pkg::MOD_ASK:  m_sel_mod = data_bit ? m_sine : 12'sd0;
				dds_pkg::MOD_FSK:  m_sel_mod = m_sine;
				dds_pkg::MOD_BPSK: m_sel_mod = data_bit ? m_sine : m_cos;
				default:           m_sel_mod = data_bit ? dds_pkg::SAMPLE_MIN : 12'sd0;
			endcase
			m_sine   = sine_of(m_phase);
			m_cos    = sine_of(m_phase + 32'h4000_0000);  // next quadrant
			m_saw    = saw_of(m_phase);
			m_square = square_of(m_phase);
			m_phase  = m_phase + inc;
			if (tick)
				m_lfsr = {m_lfsr[3:0], m_lfsr[4] ^ m_lfsr[2]};
			m_tick = tick ? 0 : m_tick + 1;
			if (key_event_ready)
			begin
				for (int k = 0; k < dds_pkg::NUM_KEYS; k++)
				begin
					if (key_event_type == dds_pkg::KEY_MAKE_CODES[k])
					begin
						m_held[k] = 1'b1;
						if (k < 4)
							m_sig_sel = 2'(k);
						else
							m_mod_sel = 2'(k - 4);
					end
					else if (key_event_type == (dds_pkg::KEY_MAKE_CODES[k] | dds_pkg::BREAK_FLAG))
						m_held[k] = 1'b0;
				end
			end
		end
	endtask

	////////////////////////////////////////////////////////////
	// stimulus and checks
	////////////////////////////////////////////////////////////
	task automatic drive_event();
		logic [31:0] r;
		logic [31:0] odd;
		int          key;
		logic [7:0]  code;
		draw_bits(2, r);
		if (r[1:0] == 2'b11)  // about one cycle in four
		begin
			draw_bits(4, r);
			case (test_id)
				0, 1: key = int'(r[2:0]);
				2: key = int'(r[1:0]);                                   // keys 1..4
				3: key = (r[1:0] == 2'd0) ? 4 : ((r[1:0] == 2'd1) ? 6 : 7);  // keys 5, 7, 8
				default: key = 5;                                        // key 6
			endcase
			code = dds_pkg::KEY_MAKE_CODES[key];
			if (r[3])
				code = code | dds_pkg::BREAK_FLAG;
			if (test_id < 2)
			begin
				draw_bits(3, odd);
				if (odd[2:0] == 3'd0)
				begin
					draw_bits(8, odd);
					code = odd[7:0];  // mostly not in the table
				end
			end
			key_event_ready <= 1'b1;
			key_event_type  <= code;
		end
		else
			key_event_ready <= 1'b0;
	endtask

	task automatic check_value(input string what, input int expected, input int actual);
		assert (expected == actual)
		else
		begin
			test_errors++;
			$display("[ERROR] %s: %s expected %0d, actual %0d",
				test_name, what, expected, actual);
		end
	endtask

	task automatic compare_outputs();
		check_value("held_keys", int'(m_held), int'(held_keys));
		check_value("lfsr_value", int'(m_lfsr), int'(lfsr_value));
		check_value("selected_signal", int'(m_sel_sig), int'(selected_signal));
		check_value("selected_modulation", int'(m_sel_mod), int'(selected_modulation));
	endtask

	// watchdog
	always @(posedge CLK_25MHZ)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= MAX_CYCLES)
		begin
			$display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
			$display("Test failures found");
			$finish;
		end
	end

	initial
	begin
		CLK_25MHZ       = 1'b0;
		reset_from_key  = 1'b1;
		key_event_ready = 1'b0;
		key_event_type  = 8'h00;
		dds_increment   = dds_pkg::BASE_PHASE_INC;
		rng_state       = 16'd19;
		test_id         = 0;
		test_name       = test_names[0];
		test_errors     = 0;
		failed_tests    = 0;
		total_errors    = 0;
		for (int c = 0; c < RESET_CYCLES; c++)
		begin
			@(posedge CLK_25MHZ);
			model_clock();
			if (c == RESET_CYCLES - 1)
				reset_from_key <= 1'b0;
			@(negedge CLK_25MHZ);
			compare_outputs();  // reset values count toward the first test
		end
		for (int t = 0; t < NUM_TESTS; t++)
		begin
			test_id   = t;
			test_name = test_names[t];
			for (int c = 0; c < TEST_CYCLES; c++)
			begin
				@(posedge CLK_25MHZ);
				model_clock();
				if (c == 0)
				begin
					draw_bits(32, rnd);
					dds_increment <= rnd;  // fresh fsk increment
				end
				drive_event();
				@(negedge CLK_25MHZ);
				compare_outputs();
			end
			if (test_errors == 0)
				$display("test %0d %s: ok over %0d cycles", t + 1, test_name, TEST_CYCLES);
			else
				$display("test %0d %s: %0d mismatches", t + 1, test_name, test_errors);
			total_errors += test_errors;
			if (test_errors != 0)
				failed_tests++;
			test_errors = 0;
		end
		$display("tests run %0d, failed %0d, mismatches %0d", NUM_TESTS, failed_tests,
			total_errors);
		if (failed_tests == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire

//--- dds_modulation_lab.sv
`timescale 1ns/1ps
`default_nettype none

module dds_modulation_lab (
	input  logic                                CLK_25MHZ,
	input  logic                                reset_from_key,
	input  logic                                key_event_ready,
	input  logic [7:0]                          key_event_type,
	input  logic [dds_pkg::PHASE_W-1:0]         dds_increment,
	output logic [dds_pkg::NUM_KEYS-1:0]        held_keys,
	output logic [dds_pkg::LFSR_W-1:0]          lfsr_value,
	output logic signed [dds_pkg::SAMPLE_W-1:0] selected_signal,
	output logic signed [dds_pkg::SAMPLE_W-1:0] selected_modulation
);

	mode_if    mode ();
	carrier_if carriers ();

	////////////////////////////////////////////////////////////
	// controls and data source
	////////////////////////////////////////////////////////////
	key_mode_control key_ctrl (
		.CLK_25MHZ       (CLK_25MHZ),
		.reset_from_key  (reset_from_key),
		.key_event_ready (key_event_ready),
		.key_event_type  (key_event_type),
		.dds_increment   (dds_increment),
		.held_keys       (held_keys),
		.mode            (mode.control)
	);

	lfsr_source lfsr_src (
		.CLK_25MHZ      (CLK_25MHZ),
		.reset_from_key (reset_from_key),
		.mode           (mode.lfsr_src)
	);

	assign lfsr_value = mode.lfsr_value;

	////////////////////////////////////////////////////////////
	// carrier generation and output select
	////////////////////////////////////////////////////////////
	dds_phase_gen phase_gen (
		.CLK_25MHZ      (CLK_25MHZ),
		.reset_from_key (reset_from_key),
		.mode           (mode.dds),
		.carriers       (carriers.source)
	);

	modulation_select mod_sel (
		.CLK_25MHZ           (CLK_25MHZ),
		.reset_from_key      (reset_from_key),
		.mode                (mode.modulator),
		.carriers            (carriers.sink),
		.selected_signal     (selected_signal),     // two clocks after phase
		.selected_modulation (selected_modulation)
	);

endmodule

`default_nettype wire

//--- modulation_select.sv
`timescale 1ns/1ps
`default_nettype none

module modulation_select (
	input  logic                                CLK_25MHZ,
	input  logic                                reset_from_key,
	mode_if.modulator                           mode,
	carrier_if.sink                             carriers,
	output logic signed [dds_pkg::SAMPLE_W-1:0] selected_signal,
	output logic signed [dds_pkg::SAMPLE_W-1:0] selected_modulation
);

	logic                                lfsr_bit;
	logic signed [dds_pkg::SAMPLE_W-1:0] signal_next;
	logic signed [dds_pkg::SAMPLE_W-1:0] modulated;

	assign lfsr_bit = mode.lfsr_value[0];

	// displayed carrier
	always_comb
	begin
		signal_next = carriers.sine;
		case (mode.signal_sel)
			dds_pkg::SIG_SINE:   signal_next = carriers.sine;
			dds_pkg::SIG_COS:    signal_next = carriers.cosine;
			dds_pkg::SIG_SAW:    signal_next = carriers.saw;
			dds_pkg::SIG_SQUARE: signal_next = carriers.square;
		endcase
	end

	// modulated sample from the data bit
	always_comb
	begin
		modulated = carriers.sine;
		case (mode.mod_sel)
			dds_pkg::MOD_ASK:  modulated = lfsr_bit ? carriers.sine : '0;
			dds_pkg::MOD_FSK:  modulated = carriers.sine;  // freq already shifted upstream
			dds_pkg::MOD_BPSK: modulated = lfsr_bit ? carriers.sine : carriers.cosine;
			dds_pkg::MOD_LFSR: modulated = lfsr_bit ? dds_pkg::SAMPLE_MIN : '0;
		endcase
	end

	always_ff @(posedge CLK_25MHZ)
	begin
		if (reset_from_key)
		begin
			selected_signal     <= '0;
			selected_modulation <= '0;
		end
		else
		begin
			selected_signal     <= signal_next;
			selected_modulation <= modulated;
		end
	end

endmodule

`default_nettype wire

//--- dds_phase_gen.sv
`timescale 1ns/1ps
`default_nettype none

module dds_phase_gen (
	input  logic      CLK_25MHZ,
	input  logic      reset_from_key,
	mode_if.dds       mode,
	carrier_if.source carriers
);

	`include "sine_quarter.svh"

	logic [dds_pkg::PHASE_W-1:0] phase_acc;
	dds_pkg::phase_word_u        phase_word;

	// quarter table folded out to a full period
	function automatic logic signed [dds_pkg::SAMPLE_W-1:0] sine_at(
		input logic [1:0] quadrant,
		input logic [3:0] offset
	);
		logic [3:0]                          addr;
		logic signed [dds_pkg::SAMPLE_W-1:0] mag;
		addr = quadrant[0] ? ~offset : offset;  // 15-offset on the falling side
		mag  = SINE_QUARTER[addr];
		return quadrant[1] ? -mag : mag;        // second half is negative
	endfunction

	////////////////////////////////////////////////////////////
	// phase accumulator
	////////////////////////////////////////////////////////////
	always_ff @(posedge CLK_25MHZ)
	begin
		if (reset_from_key)
			phase_acc <= '0;
		else
			phase_acc <= phase_acc + mode.phase_inc;  // wraps
	end

	assign phase_word = phase_acc;

	////////////////////////////////////////////////////////////
	// carriers, one register stage after the phase
	////////////////////////////////////////////////////////////
	always_ff @(posedge CLK_25MHZ)
	begin
		if (reset_from_key)
		begin
			carriers.sine   <= '0;
			carriers.cosine <= '0;
			carriers.saw    <= '0;
			carriers.square <= '0;
		end
		else
		begin
			carriers.sine   <= sine_at(phase_word.quad.quadrant, phase_word.quad.offset);
			// cos leads by one quadrant
			carriers.cosine <= sine_at(phase_word.quad.quadrant + 2'd1, phase_word.quad.offset);
			// index*64 - 2048, i.e. msb flipped
			carriers.saw    <= {~phase_word.idx.wave_index[5], phase_word.idx.wave_index[4:0], 6'd0};
			carriers.square <= phase_word.idx.wave_index[5]
				? -dds_pkg::SAMPLE_MAX
				: dds_pkg::SAMPLE_MAX;
		end
	end

endmodule

`default_nettype wire

//--- lfsr_source.sv
`timescale 1ns/1ps
`default_nettype none

module lfsr_source (
	input  logic     CLK_25MHZ,
	input  logic     reset_from_key,
	mode_if.lfsr_src mode
);

	logic [dds_pkg::LFSR_W-1:0] lfsr_q;
	logic                       feedback;

	// taps 5 and 3, maximal length from a nonzero seed
	assign feedback = lfsr_q[4] ^ lfsr_q[2];

	always_ff @(posedge CLK_25MHZ)
	begin
		if (reset_from_key)
			lfsr_q <= dds_pkg::LFSR_SEED;
		else if (mode.lfsr_tick)
			lfsr_q <= {lfsr_q[3:0], feedback};  // shift left
	end

	assign mode.lfsr_value = lfsr_q;

endmodule

`default_nettype wire

//--- key_mode_control.sv
`timescale 1ns/1ps
`default_nettype none

module key_mode_control (
	input  logic                         CLK_25MHZ,
	input  logic                         reset_from_key,
	input  logic                         key_event_ready,
	input  logic [7:0]                   key_event_type,
	input  logic [dds_pkg::PHASE_W-1:0]  dds_increment,
	output logic [dds_pkg::NUM_KEYS-1:0] held_keys,
	mode_if.control                      mode
);

	logic [dds_pkg::TICK_W-1:0] tick_cnt;
	logic                       lfsr_bit;

	////////////////////////////////////////////////////////////
	// key events
	////////////////////////////////////////////////////////////
	always_ff @(posedge CLK_25MHZ)
	begin
		if (reset_from_key)
		begin
			held_keys       <= '0;
			mode.signal_sel <= dds_pkg::SIG_SINE;
			mode.mod_sel    <= dds_pkg::MOD_ASK;
		end
		else if (key_event_ready)
		begin
			for (int k = 0; k < dds_pkg::NUM_KEYS; k++)
			begin
				if (key_event_type == dds_pkg::KEY_MAKE_CODES[k])
				begin
					held_keys[k] <= 1'b1;
					// low bits of k give key-1 for 1..4 and key-5 for 5..8
					if (k < dds_pkg::NUM_KEYS / 2)
						mode.signal_sel <= k[dds_pkg::SEL_W-1:0];
					else
						mode.mod_sel <= k[dds_pkg::SEL_W-1:0];
				end
				else if (key_event_type == (dds_pkg::KEY_MAKE_CODES[k] | dds_pkg::BREAK_FLAG))
				begin
					held_keys[k] <= 1'b0;  // break
				end
			end
		end
	end

	////////////////////////////////////////////////////////////
	// slow tick for the lfsr
	////////////////////////////////////////////////////////////
	always_ff @(posedge CLK_25MHZ)
	begin
		if (reset_from_key)
			tick_cnt <= '0;
		else if (mode.lfsr_tick)
			tick_cnt <= '0;
		else
			tick_cnt <= tick_cnt + 1'b1;
	end

	assign mode.lfsr_tick = (tick_cnt == dds_pkg::TICK_MAX);  // one cycle per period

	// fsk: data bit of one switches to the user increment
	assign lfsr_bit = mode.lfsr_value[0];
	assign mode.phase_inc = (mode.mod_sel == dds_pkg::MOD_FSK && lfsr_bit)
		? dds_increment
		: dds_pkg::BASE_PHASE_INC;

endmodule

`default_nettype wire

//--- carrier_if.sv
`timescale 1ns/1ps
`default_nettype none

interface carrier_if;

	logic signed [dds_pkg::SAMPLE_W-1:0] sine;
	logic signed [dds_pkg::SAMPLE_W-1:0] cosine;
	logic signed [dds_pkg::SAMPLE_W-1:0] saw;
	logic signed [dds_pkg::SAMPLE_W-1:0] square;

	modport source (output sine, cosine, saw, square);
	modport sink (input sine, cosine, saw, square);

endinterface

`default_nettype wire

//--- mode_if.sv
`timescale 1ns/1ps
`default_nettype none

interface mode_if;

	logic [dds_pkg::SEL_W-1:0]   signal_sel;
	logic [dds_pkg::SEL_W-1:0]   mod_sel;
	logic [dds_pkg::PHASE_W-1:0] phase_inc;
	logic                        lfsr_tick;
	logic [dds_pkg::LFSR_W-1:0]  lfsr_value;  // bit 0 is the data bit

	modport control (
		output signal_sel, mod_sel, phase_inc, lfsr_tick,
		input  lfsr_value
	);
	modport lfsr_src (input lfsr_tick, output lfsr_value);
	modport dds (input phase_inc);
	modport modulator (input signal_sel, mod_sel, lfsr_value);

endinterface

`default_nettype wire

//--- dds_pkg.sv
`default_nettype none

package dds_pkg;

	////////////////////////////////////////////////////////////
	// widths
	////////////////////////////////////////////////////////////
	localparam int SAMPLE_W = 12;  // signed samples
	localparam int PHASE_W  = 32;
	localparam int LFSR_W   = 5;
	localparam int SEL_W    = 2;
	localparam int NUM_KEYS = 8;

	// ps/2 set-2 make codes, index 0 is key 1
	localparam logic [7:0] KEY_MAKE_CODES [0:NUM_KEYS-1] = '{
		8'h16, 8'h1E, 8'h26, 8'h25, 8'h2E, 8'h36, 8'h3D, 8'h3E
	};
	localparam logic [7:0] BREAK_FLAG = 8'h80;  // make code | this = break

	// slow tick, scaled down so the lfsr moves in simulation
	localparam int LFSR_TICK_CYCLES = 40;
	localparam int TICK_W = $clog2(LFSR_TICK_CYCLES);
	localparam logic [TICK_W-1:0] TICK_MAX = TICK_W'(LFSR_TICK_CYCLES - 1);
	localparam logic [LFSR_W-1:0] LFSR_SEED = 5'b00001;

	localparam logic [PHASE_W-1:0] BASE_PHASE_INC = 32'h0100_0000;  // 256 clocks per period

	localparam logic signed [SAMPLE_W-1:0] SAMPLE_MAX = 12'sd2047;
	localparam logic signed [SAMPLE_W-1:0] SAMPLE_MIN = 12'sh800;  // -2048

	// selector encodings
	localparam logic [SEL_W-1:0] SIG_SINE   = 2'd0;
	localparam logic [SEL_W-1:0] SIG_COS    = 2'd1;
	localparam logic [SEL_W-1:0] SIG_SAW    = 2'd2;
	localparam logic [SEL_W-1:0] SIG_SQUARE = 2'd3;

	localparam logic [SEL_W-1:0] MOD_ASK  = 2'd0;
	localparam logic [SEL_W-1:0] MOD_FSK  = 2'd1;
	localparam logic [SEL_W-1:0] MOD_BPSK = 2'd2;
	localparam logic [SEL_W-1:0] MOD_LFSR = 2'd3;

	// one phase word, two ways of slicing its top bits
	typedef union packed {
		struct packed {
			logic [5:0]  wave_index;  // 64 steps per period
			logic [25:0] frac;
		} idx;
		struct packed {
			logic [1:0]  quadrant;
			logic [3:0]  offset;      // position inside the quadrant
			logic [25:0] frac;
		} quad;
	} phase_word_u;

endpackage

`default_nettype wire

//--- sine_quarter.svh
localparam logic signed [dds_pkg::SAMPLE_W-1:0] SINE_QUARTER [0:15] = '{
	// 2047*sin((k+0.5)*pi/32), first quarter only
	12'sd100,
	12'sd300,
	12'sd497,
	12'sd690,
	12'sd875,
	12'sd1052,
	12'sd1219,
	12'sd1375,
	12'sd1517,
	12'sd1644,
	12'sd1756,
	12'sd1850,
	12'sd1927,
	12'sd1986,
	12'sd2025,
	12'sd2045
};
